//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := countdown_matrix_tb
FILELIST  := countdown_matrix_top.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- countdown_ctrl.sv
`timescale 1ns/1ns
`include "countdown_matrix_settings.svh"

module countdown_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    output countdown_matrix_pkg::display_t disp,
    output logic                           busy,
    output logic                           done
);

    localparam int CNT_W = ($clog2(`COUNT_CYCLES) > 0) ? $clog2(`COUNT_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`COUNT_CYCLES - 1);

    countdown_matrix_pkg::ctrl_state_e state;
    logic [CNT_W-1:0]                  period_cnt;
    logic [2:0]                        digit;
    logic                              period_end;

    assign period_end = (period_cnt == CNT_LAST);

    // start wins in every state, so a running count restarts with a fresh period.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state      <= countdown_matrix_pkg::IDLE;
            period_cnt <= '0;
            digit      <= 3'd0;
        end
        else if (start)
        begin
            state      <= countdown_matrix_pkg::COUNT;
            period_cnt <= '0;
            digit      <= `START_DIGIT;
        end
        else
        begin
            case (state)
                countdown_matrix_pkg::COUNT:
                begin
                    if (period_end)
                    begin
                        period_cnt <= '0;
                        // the last period ends in a blank panel.
                        if (digit == 3'd1)
                        begin
                            digit <= 3'd0;
                            state <= countdown_matrix_pkg::DONE;
                        end
                        else
                        begin
                            digit <= digit - 3'd1;
                        end
                    end
                    else
                    begin
                        period_cnt <= period_cnt + 1'b1;
                    end
                end
                countdown_matrix_pkg::DONE:
                begin
                    state <= countdown_matrix_pkg::IDLE;
                end
                default:
                begin
                    state <= countdown_matrix_pkg::IDLE;
                end
            endcase
        end
    end

    assign busy = (state == countdown_matrix_pkg::COUNT);
    assign done = (state == countdown_matrix_pkg::DONE);

    always_comb
    begin
        disp.digit  = digit;
        disp.active = busy;
    end

endmodule

//--- countdown_matrix_asserts.sv
`timescale 1ns/1ns

module countdown_matrix_asserts (
    input logic       clk,
    input logic       rst,
    input logic       busy,
    input logic       done,
    input logic [7:0] row,
    input logic [7:0] colr,
    input logic [7:0] colg
);

    // only one row of the panel may be driven at a time.
    row_one_hot: assert property (
        @(posedge clk) disable iff (rst)
        (row != 8'h00) |-> $onehot(row)
    ) else $error("row select has more than one bit set");

    // green never lights alone, it only joins red to make yellow.
    green_follows_red: assert property (
        @(posedge clk) disable iff (rst)
        (colg != 8'h00) |-> (colg == colr)
    ) else $error("green columns differ from red columns");

    done_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    ) else $error("done stayed high for more than one cycle");

    done_ends_busy: assert property (
        @(posedge clk) disable iff (rst)
        done |-> (!busy && $past(busy))
    ) else $error("done did not coincide with the fall of busy");

    busy_falls_with_done: assert property (
        @(posedge clk) disable iff (rst)
        $fell(busy) |-> done
    ) else $error("busy fell without a done pulse");

endmodule

bind countdown_matrix_top countdown_matrix_asserts asserts0 (
    .clk  (clk),
    .rst  (rst),
    .busy (busy),
    .done (done),
    .row  (row),
    .colr (colr),
    .colg (colg)
);

//--- countdown_matrix_pkg.sv
package countdown_matrix_pkg;

    // controller states.
    // DONE lasts a single cycle and then falls back to IDLE.
    typedef enum logic [1:0]
    {
        IDLE  = 2'd0,
        COUNT = 2'd1,
        DONE  = 2'd2
    } ctrl_state_e;

    // digit currently on display.
    // a digit of 0 means the panel is blank.
    typedef struct packed
    {
        logic [2:0] digit;
        logic       active;
    } display_t;

    // row scan position.
    // step is high for one cycle right after index has moved on.
    typedef struct packed
    {
        logic [2:0] index;
        logic       step;
    } scan_t;

endpackage

//--- countdown_matrix_settings.svh
`ifndef COUNTDOWN_MATRIX_SETTINGS_SVH
`define COUNTDOWN_MATRIX_SETTINGS_SVH

// clock cycles each digit stays on the panel.
// a board build sets this to the clock rate for one second per digit.
`define COUNT_CYCLES 64

// clock cycles each matrix row stays selected.
`define SCAN_CYCLES 2

// first digit shown after start.
`define START_DIGIT 3'd5

`endif

//--- countdown_matrix_tb.sv
`timescale 1ns/1ns
`include "countdown_matrix_settings.svh"

module countdown_matrix_tb;

    localparam int CLK_PERIOD_NS = 40;
    localparam int RUN_CYCLES = 5 * `COUNT_CYCLES;
    // four full countdowns plus three more as margin for the waits and the restart.
    localparam longint WATCHDOG_NS = longint'((4 + 3) * RUN_CYCLES) * CLK_PERIOD_NS;

    logic       clk;
    logic       rst;
    logic       start;
    logic       busy;
    logic       done;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) clock0 (.clk(clk));

    countdown_matrix_top dut0 (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .busy  (busy),
        .done  (done),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

    task automatic fail_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_cols(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected)
        begin
            $display("Error: %s expected %h got %h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_row(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
        if (actual !== expected)
        begin
            $display("Error: %s expected row %h got %h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Error: %s expected %b got %b", name, expected, actual);
            fail_run();
        end
    endtask

    // glyph rows packed top row first, row 0 in the upper byte.
    function automatic logic [7:0] glyph_row(input logic [2:0] digit, input logic [2:0] idx);
        logic [63:0] rows;
        logic [63:0] shifted;
        case (digit)
            3'd5: rows = 64'h00_7E_60_7C_06_06_66_3C;
            3'd4: rows = 64'h00_0C_1C_2C_4C_7E_0C_0C;
            3'd3: rows = 64'h00_3C_66_06_1C_06_66_3C;
            3'd2: rows = 64'h00_3C_66_06_0C_30_60_7E;
            3'd1: rows = 64'h00_18_18_38_0C_30_60_7E;
            default: rows = 64'h0;
        endcase
        shifted = rows >> (8 * (7 - int'(idx)));
        return shifted[7:0];
    endfunction

    function automatic logic shows_yellow(input logic [2:0] digit);
        return (digit >= 3'd1) && (digit <= 3'd3);
    endfunction

    // digit seen on the columns n edges after the start edge, one cycle behind the count.
    function automatic logic [2:0] panel_digit(input int n);
        if (n < 1 || n > RUN_CYCLES)
        begin
            return 3'd0;
        end
        return 3'(`START_DIGIT - (n - 1) / `COUNT_CYCLES);
    endfunction

    function automatic logic [2:0] row_to_index(input logic [7:0] sel);
        logic [2:0] idx;
        idx = 3'd0;
        for (int i = 7; i >= 0; i--)
        begin
            if (sel[i])
            begin
                idx = 3'(i);
            end
        end
        return idx;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        tick();
        start = 1'b0;
    endtask

    task automatic check_panel(input string name, input int n);
        logic [2:0] digit;
        logic [2:0] idx;
        logic [7:0] pattern;
        digit = panel_digit(n);
        idx = row_to_index(row);
        pattern = glyph_row(digit, idx);
        check_row(name, 8'h01 << idx, row);
        check_cols({name, " red"}, pattern, colr);
        check_cols({name, " green"}, shows_yellow(digit) ? pattern : 8'h00, colg);
    endtask

    // follows the count from edge from_n until done, checking busy and done every cycle.
    task automatic run_to_done(input string name, input int from_n);
        int n;
        n = from_n;
        while (done !== 1'b1)
        begin
            tick();
            n++;
            if (n > RUN_CYCLES + 2)
            begin
                $display("%s: done never arrived after the start pulse", name);
                fail_run();
            end
            check_flag({name, " busy"}, n < RUN_CYCLES, busy);
            check_flag({name, " done"}, n == RUN_CYCLES, done);
        end
        tick();
        check_flag({name, " done width"}, 1'b0, done);
        check_flag({name, " busy after done"}, 1'b0, busy);
    endtask

    task automatic test_reset_state();
        string name;
        logic [7:0] expected_row;
        name = "reset_state";
        repeat (2)
        begin
            tick();
            check_flag({name, " busy"}, 1'b0, busy);
            check_flag({name, " done"}, 1'b0, done);
            check_row(name, 8'h00, row);
            check_cols({name, " red"}, 8'h00, colr);
            check_cols({name, " green"}, 8'h00, colg);
        end
        rst = 1'b0;
        repeat (8 * `SCAN_CYCLES)
        begin
            tick();
            check_flag({name, " busy"}, 1'b0, busy);
            check_flag({name, " done"}, 1'b0, done);
            check_cols({name, " red"}, 8'h00, colr);
            check_cols({name, " green"}, 8'h00, colg);
            expected_row = (row == 8'h00) ? 8'h00 : (8'h01 << row_to_index(row));
            check_row(name, expected_row, row);
        end
    endtask

    task automatic test_digit5_red();
        string name;
        int n;
        logic [7:0] seen;
        name = "digit5_red";
        seen = 8'h00;
        pulse_start();
        n = 0;
        repeat (8 * `SCAN_CYCLES + 1)
        begin
            tick();
            n++;
            check_panel(name, n);
            seen = seen | row;
        end
        if (seen != 8'hFF)
        begin
            $display("%s: the scan did not visit every row, rows seen %h", name, seen);
            fail_run();
        end
        run_to_done(name, n);
    endtask

    task automatic test_countdown_timing();
        string name;
        name = "countdown_timing";
        check_flag({name, " idle busy"}, 1'b0, busy);
        pulse_start();
        check_flag({name, " busy rise"}, 1'b1, busy);
        check_flag({name, " done"}, 1'b0, done);
        run_to_done(name, 0);
    endtask

    task automatic test_yellow_digits();
        string name;
        int n;
        int first;
        pulse_start();
        n = 0;
        for (int d = 3; d >= 1; d--)
        begin
            name = $sformatf("yellow_digit_%0d", d);
            first = (5 - d) * `COUNT_CYCLES + `COUNT_CYCLES / 2 - 8;
            while (n < first)
            begin
                tick();
                n++;
            end
            repeat (8 * `SCAN_CYCLES)
            begin
                tick();
                n++;
                check_panel(name, n);
            end
        end
        run_to_done("yellow_digits", n);
    endtask

    task automatic test_restart();
        string name;
        int n;
        name = "restart";
        pulse_start();
        n = 0;
        while (n < 3 * `COUNT_CYCLES + `COUNT_CYCLES / 2)
        begin
            tick();
            n++;
        end
        check_panel({name, " digit 2"}, n);
        pulse_start();
        n = 0;
        check_flag({name, " busy"}, 1'b1, busy);
        check_flag({name, " done"}, 1'b0, done);
        repeat (8 * `SCAN_CYCLES + 1)
        begin
            tick();
            n++;
            check_panel(name, n);
        end
        run_to_done(name, n);
    endtask

    task automatic test_blank_after_done();
        string name;
        logic [7:0] prev;
        logic [7:0] expected_row;
        int changes;
        int n;
        name = "blank_after_done";
        prev = row;
        changes = 0;
        repeat (8 * `SCAN_CYCLES + 2)
        begin
            tick();
            check_cols({name, " red"}, 8'h00, colr);
            check_cols({name, " green"}, 8'h00, colg);
            check_flag({name, " busy"}, 1'b0, busy);
            check_flag({name, " done"}, 1'b0, done);
            expected_row = (row == prev) ? prev : {prev[6:0], prev[7]};
            check_row(name, expected_row, row);
            if (row != prev)
            begin
                changes++;
            end
            prev = row;
        end
        if (changes < 8)
        begin
            $display("%s: row stopped stepping, only %0d changes seen", name, changes);
            fail_run();
        end
        pulse_start();
        n = 0;
        check_flag({name, " new start busy"}, 1'b1, busy);
        repeat (8 * `SCAN_CYCLES + 1)
        begin
            tick();
            n++;
            check_panel({name, " new start"}, n);
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog: the tests did not finish within %0d ns", WATCHDOG_NS);
        fail_run();
    end

    initial
    begin
        rst = 1'b1;
        start = 1'b0;
        test_reset_state();
        test_digit5_red();
        test_countdown_timing();
        test_yellow_digits();
        test_restart();
        test_blank_after_done();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- countdown_matrix_top.f
+incdir+.
countdown_matrix_pkg.sv
countdown_ctrl.sv
row_scanner.sv
matrix_glyph.sv
countdown_matrix_top.sv
tb_clock.sv
countdown_matrix_asserts.sv
countdown_matrix_tb.sv

//--- countdown_matrix_top.sv
`timescale 1ns/1ns

module countdown_matrix_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    output logic       busy,
    output logic       done,
    output logic [7:0] row,
    output logic [7:0] colr,
    output logic [7:0] colg
);

    countdown_matrix_pkg::display_t disp;
    countdown_matrix_pkg::scan_t    scan;

    countdown_ctrl u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .disp  (disp),
        .busy  (busy),
        .done  (done)
    );

    // the scanner runs freely and ignores the countdown.
    row_scanner u_scanner (
        .clk  (clk),
        .rst  (rst),
        .scan (scan)
    );

    matrix_glyph u_glyph (
        .clk  (clk),
        .rst  (rst),
        .disp (disp),
        .scan (scan),
        .row  (row),
        .colr (colr),
        .colg (colg)
    );

endmodule

//--- matrix_glyph.sv
`timescale 1ns/1ns

module matrix_glyph (
    input  logic                           clk,
    input  logic                           rst,
    input  countdown_matrix_pkg::display_t disp,
    input  countdown_matrix_pkg::scan_t    scan,
    output logic [7:0]                     row,
    output logic [7:0]                     colr,
    output logic [7:0]                     colg
);

    logic [7:0] pattern;
    logic       yellow;

    // column bits for one row of one digit.
    // row 0 is the top margin and stays dark for every digit.
    function automatic logic [7:0] glyph_bits(input logic [2:0] digit, input logic [2:0] idx);
        logic [7:0] bits;
        bits = 8'h00;
        case (digit)
            3'd5:
            begin
                case (idx)
                    3'd1: bits = 8'h7E;
                    3'd2: bits = 8'h60;
                    3'd3: bits = 8'h7C;
                    3'd4: bits = 8'h06;
                    3'd5: bits = 8'h06;
                    3'd6: bits = 8'h66;
                    3'd7: bits = 8'h3C;
                    default: bits = 8'h00;
                endcase
            end
            3'd4:
            begin
                case (idx)
                    3'd1: bits = 8'h0C;
                    3'd2: bits = 8'h1C;
                    3'd3: bits = 8'h2C;
                    3'd4: bits = 8'h4C;
                    3'd5: bits = 8'h7E;
                    3'd6: bits = 8'h0C;
                    3'd7: bits = 8'h0C;
                    default: bits = 8'h00;
                endcase
            end
            3'd3:
            begin
                case (idx)
                    3'd1: bits = 8'h3C;
                    3'd2: bits = 8'h66;
                    3'd3: bits = 8'h06;
                    3'd4: bits = 8'h1C;
                    3'd5: bits = 8'h06;
                    3'd6: bits = 8'h66;
                    3'd7: bits = 8'h3C;
                    default: bits = 8'h00;
                endcase
            end
            3'd2:
            begin
                case (idx)
                    3'd1: bits = 8'h3C;
                    3'd2: bits = 8'h66;
                    3'd3: bits = 8'h06;
                    3'd4: bits = 8'h0C;
                    3'd5: bits = 8'h30;
                    3'd6: bits = 8'h60;
                    3'd7: bits = 8'h7E;
                    default: bits = 8'h00;
                endcase
            end
            3'd1:
            begin
                // the lower rows of 1 follow the shape of 2.
                case (idx)
                    3'd1: bits = 8'h18;
                    3'd2: bits = 8'h18;
                    3'd3: bits = 8'h38;
                    3'd4: bits = 8'h0C;
                    3'd5: bits = 8'h30;
                    3'd6: bits = 8'h60;
                    3'd7: bits = 8'h7E;
                    default: bits = 8'h00;
                endcase
            end
            default:
            begin
                bits = 8'h00;
            end
        endcase
        return bits;
    endfunction

    // the panel stays dark whenever no countdown is running.
    always_comb
    begin
        if (disp.active)
        begin
            pattern = glyph_bits(disp.digit, scan.index);
        end
        else
        begin
            pattern = 8'h00;
        end
        yellow = (disp.digit == 3'd3) || (disp.digit == 3'd2) || (disp.digit == 3'd1);
    end

    // yellow is red and green lit together.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            colr <= 8'h00;
            colg <= 8'h00;
        end
        else
        begin
            colr <= pattern;
            colg <= yellow ? pattern : 8'h00;
        end
    end

    // row select only moves when the scanner steps, so no row is driven twice.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row <= 8'h00;
        end
        else if (scan.step)
        begin
            row <= 8'h01 << scan.index;
        end
    end

endmodule

//--- row_scanner.sv
`timescale 1ns/1ns
`include "countdown_matrix_settings.svh"

module row_scanner (
    input  logic                        clk,
    input  logic                        rst,
    output countdown_matrix_pkg::scan_t scan
);

    localparam int PRE_W = ($clog2(`SCAN_CYCLES) > 0) ? $clog2(`SCAN_CYCLES) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`SCAN_CYCLES - 1);

    logic [PRE_W-1:0] pre_cnt;
    logic [2:0]       row_idx;
    logic             row_step;

    // the row index wraps from 7 back to 0 on its own.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pre_cnt  <= '0;
            row_idx  <= 3'd0;
            row_step <= 1'b0;
        end
        else if (pre_cnt == PRE_LAST)
        begin
            pre_cnt  <= '0;
            row_idx  <= row_idx + 3'd1;
            row_step <= 1'b1;
        end
        else
        begin
            pre_cnt  <= pre_cnt + 1'b1;
            row_step <= 1'b0;
        end
    end

    always_comb
    begin
        scan.index = row_idx;
        scan.step  = row_step;
    end

endmodule

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule
